// File: list.f
rtl/wl_pkg.sv
rtl/layer_cfg_regs.sv
rtl/weight_load_controller.sv
rtl/glb_sram.sv
rtl/pe_weight_array.sv
rtl/wl_top.sv
test/tb_clk_gen.sv
test/wl_tb.sv

// File: Makefile
TOP = wl_tb

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: test/wl_tb.sv
`timescale 1ns/10ps
module wl_tb;

    // six loads at worst case length, GLB preload, six sweeps, reset, slack
    localparam int TIMEOUT_CYC = 6 * (wl_pkg::WNUM_STANDARD + 10) + (wl_pkg::GLB_DEPTH + 4)
                               + 6 * (wl_pkg::PE_NUM + 4) + 4 + 200;

    logic                          clk;
    logic                          rst_n;
    logic                          cfg_we_i;
    logic                          cfg_addr_i;
    logic [31:0]                   cfg_wdata_i;
    logic                          start_i;
    logic                          glb_we_i;
    logic [wl_pkg::GLB_AW-1:0]     glb_waddr_i;
    logic [31:0]                   glb_wdata_i;
    logic [wl_pkg::PE_SEL_W-1:0]   pe_sel_i;
    logic [7:0]                    pe_weight_o;
    logic                          busy_o;
    logic                          done_o;

    logic                check_rd;                      // readback sweep running
    logic [31:0]         rnd;                           // LCG state
    logic [31:0]         mirror [wl_pkg::GLB_DEPTH];    // copy of the GLB words
    logic [7:0]          exp_w [wl_pkg::PE_NUM];        // expected cell weights
    logic [7:0]          exp_rd;
    wl_pkg::layer_type_t cfg_layer_ref;                 // host copy of the descriptor
    logic [31:0]         cfg_base_ref;
    wl_pkg::layer_type_t act_layer;                     // descriptor of the running load
    logic [31:0]         act_base;
    int                  exp_n;
    int                  busy_cyc;                      // busy cycles before this one
    int                  start_cnt;                     // starts taken while idle
    int                  done_cnt;
    int                  cyc_cnt = 0;
    int                  val_errs = 0;
    int                  proto_errs = 0;

    tb_clk_gen u_clk (.clk_o(clk));

    wl_top wl_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .start_i     (start_i),
        .glb_we_i    (glb_we_i),
        .glb_waddr_i (glb_waddr_i),
        .glb_wdata_i (glb_wdata_i),
        .pe_sel_i    (pe_sel_i),
        .pe_weight_o (pe_weight_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // byte A sits in lane A mod 4 of word A/4
    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        logic [31:0] w;
        w = mirror[addr[wl_pkg::GLB_AW+1:2]];
        return w[{addr[1:0], 3'b000} +: 8];
    endfunction

    function automatic int weight_count(input wl_pkg::layer_type_t lt);
        case (lt)
            wl_pkg::POINTWISE: return wl_pkg::WNUM_POINTWISE;
            wl_pkg::LINEAR:    return wl_pkg::WNUM_LINEAR;
            wl_pkg::DEPTHWISE: return wl_pkg::WNUM_DEPTHWISE;
            default:           return wl_pkg::WNUM_STANDARD;
        endcase
    endfunction

    function automatic logic fills_array(input wl_pkg::layer_type_t lt);
        return (lt == wl_pkg::POINTWISE) || (lt == wl_pkg::LINEAR);
    endfunction

    // reference model of descriptor, start acceptance and final cell contents
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_layer_ref <= wl_pkg::CONV_STANDARD;
            cfg_base_ref  <= '0;
            act_layer     <= wl_pkg::CONV_STANDARD;
            act_base      <= '0;
            start_cnt     <= 0;
            done_cnt      <= 0;
            for (int i = 0; i < wl_pkg::PE_NUM; i++)
                exp_w[i] <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == wl_pkg::CFG_LAYER)
                cfg_layer_ref <= wl_pkg::layer_type_t'(cfg_wdata_i[1:0]);
            if (cfg_we_i && cfg_addr_i == wl_pkg::CFG_BASE)
                cfg_base_ref <= cfg_wdata_i;
            if (start_i && !busy_o) begin                 // idle start latches the descriptor
                act_layer <= cfg_layer_ref;
                act_base  <= cfg_base_ref;
                start_cnt <= start_cnt + 1;
            end
            if (done_o) begin
                done_cnt <= done_cnt + 1;
                if (fills_array(act_layer)) begin         // cell i gets byte base+i
                    for (int i = 0; i < wl_pkg::PE_NUM; i++)
                        exp_w[i] <= ref_byte(act_base + 32'(i));
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            busy_cyc <= 0;
        else if (busy_o)
            busy_cyc <= busy_cyc + 1;
        else
            busy_cyc <= 0;
    end

    assign exp_rd = exp_w[pe_sel_i];
    assign exp_n  = weight_count(act_layer);

    a_weight: assert property (@(posedge clk) disable iff (!rst_n)
        check_rd |-> pe_weight_o == exp_rd)
        else begin
            val_errs++;
            $display("[ERROR] pe_weight_o cell %h: got %h expected %h",
                     $sampled(pe_sel_i), $sampled(pe_weight_o), $sampled(exp_rd));
        end

    a_idle_rd: assert property (@(posedge clk) disable iff (!rst_n)
        check_rd |-> !busy_o && !done_o)
        else begin
            proto_errs++;
            $display("[ERROR] busy_o/done_o in readback: got %h/%h expected 0/0",
                     $sampled(busy_o), $sampled(done_o));
        end

    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> busy_o)
        else begin
            proto_errs++;
            $display("done_o was raised while the DUT was not busy");
        end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
        else begin
            proto_errs++;
            $display("done_o stayed high for more than one cycle");
        end

    a_busy_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !busy_o)
        else begin
            proto_errs++;
            $display("busy_o did not fall in the cycle after done_o");
        end

    a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy_o) |-> $past(done_o))
        else begin
            proto_errs++;
            $display("busy_o fell without a done_o pulse");
        end

    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_i && !busy_o |=> busy_o)
        else begin
            proto_errs++;
            $display("busy_o did not rise one cycle after an idle start");
        end

    // done lands in busy cycle N+1 counting from 0
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> busy_cyc == exp_n + 1)
        else begin
            proto_errs++;
            $display("[ERROR] busy_cyc at done_o: got %h expected %h",
                     $sampled(busy_cyc), $sampled(exp_n) + 1);
        end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o |-> busy_cyc <= exp_n + 1)
        else begin
            proto_errs++;
            $display("[ERROR] busy_cyc ran past done: got %h limit %h",
                     $sampled(busy_cyc), $sampled(exp_n) + 1);
        end

    a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o |-> done_cnt == start_cnt)
        else begin
            proto_errs++;
            $display("[ERROR] done_o count when idle: got %h expected %h",
                     $sampled(done_cnt), $sampled(start_cnt));
        end

    task automatic report_counts();
        $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                               // drive after the edge
    endtask

    task automatic write_cfg(input logic addr, input logic [31:0] data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        next_cycle();
        cfg_we_i    = 1'b0;
    endtask

    task automatic configure(input wl_pkg::layer_type_t lt, input logic [31:0] base);
        write_cfg(wl_pkg::CFG_LAYER, {30'd0, lt});
        write_cfg(wl_pkg::CFG_BASE, base);
    endtask

    task automatic pulse_start();
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
    endtask

    task automatic wait_load_end();
        while (!done_o)
            next_cycle();
        while (busy_o)
            next_cycle();
    endtask

    task automatic run_load(input wl_pkg::layer_type_t lt, input logic [31:0] base);
        configure(lt, base);
        pulse_start();
        wait_load_end();
    endtask

    task automatic preload_glb();
        for (int w = 0; w < wl_pkg::GLB_DEPTH; w++) begin
            rnd         = lcg_next(rnd);
            mirror[w]   = rnd;
            glb_we_i    = 1'b1;
            glb_waddr_i = wl_pkg::GLB_AW'(w);
            glb_wdata_i = rnd;
            next_cycle();
        end
        glb_we_i = 1'b0;
    endtask

    task automatic sweep_weights();
        check_rd = 1'b1;
        for (int i = 0; i < wl_pkg::PE_NUM; i++) begin
            pe_sel_i = wl_pkg::PE_SEL_W'(i);
            next_cycle();
        end
        check_rd = 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = 1'b0;
        cfg_wdata_i = '0;
        start_i     = 1'b0;
        glb_we_i    = 1'b0;
        glb_waddr_i = '0;
        glb_wdata_i = '0;
        pe_sel_i    = '0;
        check_rd    = 1'b0;
        rnd         = 32'd55;                             // LCG seed
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        sweep_weights();                                  // reset values
        preload_glb();
        run_load(wl_pkg::POINTWISE, 32'h0000_0040);       // word aligned
        sweep_weights();
        run_load(wl_pkg::LINEAR, 32'h0000_0123);          // lane 3 base that crosses words
        sweep_weights();
        run_load(wl_pkg::DEPTHWISE, 32'h0000_0200);
        run_load(wl_pkg::CONV_STANDARD, 32'h0000_02f1);
        sweep_weights();                                  // array left alone

        configure(wl_pkg::POINTWISE, 32'h0000_0080);
        pulse_start();
        repeat (20) next_cycle();
        configure(wl_pkg::CONV_STANDARD, 32'h0000_0300);  // host copy only
        pulse_start();                                    // dropped while the load runs
        wait_load_end();
        sweep_weights();                                  // still base 0x80 bytes

        rnd = lcg_next(rnd);
        run_load(wl_pkg::LINEAR, {23'd0, rnd[8:0]});      // random base in range
        sweep_weights();
        repeat (4) next_cycle();

        if (start_cnt != 6) begin
            proto_errs++;
            $display("[ERROR] start_cnt: got %h expected %h", start_cnt, 6);
        end
        if (done_cnt != 6) begin
            proto_errs++;
            $display("[ERROR] done_cnt: got %h expected %h", done_cnt, 6);
        end
        report_counts();
        if (val_errs + proto_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // hard stop in case done_o never shows up
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt == TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            report_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps
module tb_clk_gen (
    output logic clk_o
);

    localparam time HALF = 20ns;   // 40 ns period

    initial begin
        clk_o = 1'b0;
        forever #(HALF) clk_o = ~clk_o;
    end

endmodule

// File: rtl/wl_top.sv
`timescale 1ns/10ps
module wl_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // descriptor write
    input  logic                          cfg_we_i,
    input  logic                          cfg_addr_i,
    input  logic [31:0]                   cfg_wdata_i,
    input  logic                          start_i,
    // GLB preload
    input  logic                          glb_we_i,
    input  logic [wl_pkg::GLB_AW-1:0]     glb_waddr_i,
    input  logic [31:0]                   glb_wdata_i,
    // weight readback
    input  logic [wl_pkg::PE_SEL_W-1:0]   pe_sel_i,
    output logic [7:0]                    pe_weight_o,
    // status
    output logic                          busy_o,
    output logic                          done_o
);

    logic                          load_state;
    wl_pkg::layer_type_t           layer_type;
    logic [wl_pkg::ADDR_W-1:0]     base_addr;
    logic                          web;
    logic [wl_pkg::ADDR_W-1:0]     weight_addr;
    wl_pkg::byte_type_t            byte_type;
    logic [wl_pkg::PE_NUM-1:0]     w_load_en;
    logic                          done;
    logic [7:0]                    rd_byte;

    layer_cfg_regs u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .start_i      (start_i),
        .load_done_i  (done),
        .layer_type_o (layer_type),
        .base_addr_o  (base_addr),
        .load_state_o (load_state)
    );

    weight_load_controller u_ctrl (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .weight_load_state_i     (load_state),
        .layer_type_i            (layer_type),
        .weight_glb_base_addr_i  (base_addr),
        .weight_load_web_o       (web),
        .weight_addr_o           (weight_addr),
        .weight_load_byte_type_o (byte_type),
        .w_load_en_o             (w_load_en),
        .weight_load_done_o      (done)
    );

    glb_sram u_glb (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_we_i    (glb_we_i),
        .host_waddr_i (glb_waddr_i),
        .host_wdata_i (glb_wdata_i),
        .rd_addr_i    (weight_addr),
        .byte_type_i  (byte_type),
        .web_i        (web),
        .rd_byte_o    (rd_byte)
    );

    pe_weight_array u_pe (
        .clk         (clk),
        .rst_n       (rst_n),
        .w_load_en_i (w_load_en),
        .weight_i    (rd_byte),
        .sel_i       (pe_sel_i),
        .weight_o    (pe_weight_o)
    );

    assign busy_o = load_state;  // busy is the load-state level
    assign done_o = done;

endmodule

// File: rtl/pe_weight_array.sv
`timescale 1ns/10ps
module pe_weight_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [wl_pkg::PE_NUM-1:0]     w_load_en_i,  // one enable per cell, row-major
    input  logic [7:0]                    weight_i,     // byte from the GLB
    input  logic [wl_pkg::PE_SEL_W-1:0]   sel_i,        // readback cell
    output logic [7:0]                    weight_o
);

    localparam int ROW_W = $clog2(wl_pkg::PE_ROWS);
    localparam int COL_W = $clog2(wl_pkg::PE_COLS);

    logic [7:0] w_q [wl_pkg::PE_ROWS][wl_pkg::PE_COLS];
    logic [ROW_W-1:0] sel_row;
    logic [COL_W-1:0] sel_col;

    // every cell loads on its own enable, holds otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < wl_pkg::PE_ROWS; r++) begin
                for (int c = 0; c < wl_pkg::PE_COLS; c++) begin
                    w_q[r][c] <= '0;
                end
            end
        end else begin
            for (int r = 0; r < wl_pkg::PE_ROWS; r++) begin
                for (int c = 0; c < wl_pkg::PE_COLS; c++) begin
                    if (w_load_en_i[r*wl_pkg::PE_COLS + c])
                        w_q[r][c] <= weight_i;
                end
            end
        end
    end

    // row-major select, upper bits are the row
    assign sel_row = sel_i[COL_W +: ROW_W];
    assign sel_col = sel_i[COL_W-1:0];

    assign weight_o = w_q[sel_row][sel_col];  // combinational readback

endmodule

// File: rtl/glb_sram.sv
`timescale 1ns/10ps
module glb_sram (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           host_we_i,     // preload write
    input  logic [wl_pkg::GLB_AW-1:0]      host_waddr_i,  // word address
    input  logic [31:0]                    host_wdata_i,
    input  logic [wl_pkg::ADDR_W-1:0]      rd_addr_i,     // byte address
    input  wl_pkg::byte_type_t             byte_type_i,   // lane, one cycle behind rd_addr_i
    input  logic                           web_i,         // 0 = read
    output logic [7:0]                     rd_byte_o
);

    wl_pkg::glb_word_u mem [wl_pkg::GLB_DEPTH];
    wl_pkg::glb_word_u rd_word_q;                         // registered read word
    logic [wl_pkg::GLB_AW-1:0] rd_widx;

    assign rd_widx = rd_addr_i[wl_pkg::GLB_AW+1:2];       // drop the lane bits

    // host preload port, whole-word view
    always_ff @(posedge clk) begin
        if (host_we_i)
            mem[host_waddr_i].word <= host_wdata_i;
    end

    // one cycle read delay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_word_q <= '0;
        else if (!web_i)
            rd_word_q <= mem[rd_widx];
    end

    // byte view of the same word picks the lane
    assign rd_byte_o = rd_word_q.bytes[byte_type_i];

endmodule

// File: rtl/weight_load_controller.sv
`timescale 1ns/10ps
module weight_load_controller (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             weight_load_state_i,     // busy level
    input  wl_pkg::layer_type_t              layer_type_i,
    input  logic [wl_pkg::ADDR_W-1:0]        weight_glb_base_addr_i,  // first weight byte
    output logic                             weight_load_web_o,       // 0 = read
    output logic [wl_pkg::ADDR_W-1:0]        weight_addr_o,           // byte address to GLB
    output wl_pkg::byte_type_t               weight_load_byte_type_o, // lane of the read word
    output logic [wl_pkg::PE_NUM-1:0]        w_load_en_o,             // one-hot cell enables
    output logic                             weight_load_done_o
);

    logic [wl_pkg::CNT_W-1:0]  weight_num;      // weights for this layer
    logic [wl_pkg::CNT_W-1:0]  weight_read_cnt; // cycles spent in load state
    logic                      pe_load;         // layer type that fills the array
    logic [wl_pkg::PE_NUM-1:0] en_d;

    // the controller never writes to the GLB
    assign weight_load_web_o = 1'b0;

    always_comb begin
        case (layer_type_i)
            wl_pkg::POINTWISE: weight_num = wl_pkg::CNT_W'(wl_pkg::WNUM_POINTWISE);
            wl_pkg::LINEAR:    weight_num = wl_pkg::CNT_W'(wl_pkg::WNUM_LINEAR);
            wl_pkg::DEPTHWISE: weight_num = wl_pkg::CNT_W'(wl_pkg::WNUM_DEPTHWISE);
            default:           weight_num = wl_pkg::CNT_W'(wl_pkg::WNUM_STANDARD);
        endcase
    end

    // only 1x1 style layers map one weight per cell
    assign pe_load = (layer_type_i == wl_pkg::POINTWISE) || (layer_type_i == wl_pkg::LINEAR);

    // counter is 0 in the first load-state cycle, idles at 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            weight_read_cnt <= '0;
        else if (weight_load_state_i)
            weight_read_cnt <= weight_read_cnt + 1'b1;
        else
            weight_read_cnt <= '0;
    end

    // address is base at cnt 1, then base + cnt - 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            weight_addr_o <= '0;
        else if (!weight_load_state_i)
            weight_addr_o <= '0;
        else if (weight_read_cnt == '0)
            weight_addr_o <= weight_glb_base_addr_i;
        else
            weight_addr_o <= weight_addr_o + 1'b1;
    end

    // lane follows the address by one cycle, lines up with the SRAM read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            weight_load_byte_type_o <= wl_pkg::LOAD_1BYTE;
        else
            weight_load_byte_type_o <= wl_pkg::byte_type_t'(weight_addr_o[1:0]);
    end

    // byte for cell i arrives while cnt == i+2, so decode i+1 one cycle early
    always_comb begin
        for (int i = 0; i < wl_pkg::PE_NUM; i++) begin
            en_d[i] = weight_load_state_i && pe_load &&
                      (weight_read_cnt == wl_pkg::CNT_W'(i + 1));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            w_load_en_o <= '0;
        else
            w_load_en_o <= en_d;
    end

    // done lands after N+1 load-state cycles, lasts one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            weight_load_done_o <= 1'b0;
        else
            weight_load_done_o <= weight_load_state_i && (weight_read_cnt == weight_num);
    end

    a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(w_load_en_o))
        else $error("w_load_en_o not one-hot: %h", w_load_en_o);

    // done only while the config block still holds load state
    a_done_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        weight_load_done_o |-> weight_load_state_i)
        else $error("weight_load_done_o outside load state");

endmodule

// File: rtl/layer_cfg_regs.sv
`timescale 1ns/10ps
module layer_cfg_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_we_i,      // host register write strobe
    input  logic                 cfg_addr_i,    // CFG_LAYER or CFG_BASE
    input  logic [31:0]          cfg_wdata_i,
    input  logic                 start_i,       // one-cycle start strobe
    input  logic                 load_done_i,   // done from the controller ends the load
    output wl_pkg::layer_type_t  layer_type_o,  // descriptor in use by the load
    output logic [31:0]          base_addr_o,
    output logic                 load_state_o   // busy level
);

    wl_pkg::layer_type_t cfg_layer_q;           // host view of the descriptor
    logic [31:0]         cfg_base_q;
    logic                start_ok;

    assign start_ok = start_i && !load_state_o; // starts while busy are dropped

    // host-side descriptor registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_layer_q <= wl_pkg::CONV_STANDARD;
            cfg_base_q  <= '0;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == wl_pkg::CFG_LAYER)
                cfg_layer_q <= wl_pkg::layer_type_t'(cfg_wdata_i[1:0]);
            else
                cfg_base_q <= cfg_wdata_i;
        end
    end

    // active copy frozen at start so host writes during a load do no harm
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_type_o <= wl_pkg::CONV_STANDARD;
            base_addr_o  <= '0;
        end else if (start_ok) begin
            layer_type_o <= cfg_layer_q;
            base_addr_o  <= cfg_base_q;
        end
    end

    // load-state level set by start and cleared by done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            load_state_o <= 1'b0;
        else if (start_ok)
            load_state_o <= 1'b1;
        else if (load_done_i)
            load_state_o <= 1'b0;
    end

    // descriptor seen by the controller holds for the whole load
    a_desc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        load_state_o && $past(load_state_o) |-> $stable(layer_type_o) && $stable(base_addr_o))
        else $error("descriptor changed during a load");

endmodule

// File: rtl/wl_pkg.sv
package wl_pkg;

    // layer codes as written by the host into the descriptor
    typedef enum logic [1:0] {
        CONV_STANDARD = 2'd0,
        DEPTHWISE     = 2'd1,
        LINEAR        = 2'd2,
        POINTWISE     = 2'd3
    } layer_type_t;

    // PE array geometry
    localparam int PE_ROWS  = 8;
    localparam int PE_COLS  = 8;
    localparam int PE_NUM   = PE_ROWS * PE_COLS;   // 64 cells
    localparam int PE_SEL_W = $clog2(PE_NUM);      // readback select width

    // weights per layer, scaled down with the array
    localparam int WNUM_POINTWISE = PE_NUM;        // one weight per cell
    localparam int WNUM_LINEAR    = PE_NUM;
    localparam int WNUM_DEPTHWISE = 3 * 3 * 4;     // 3x3 kernel, 4 channels
    localparam int WNUM_STANDARD  = 3 * 3 * 4 * 4; // 3x3 kernel, 4 in x 4 out

    localparam int CNT_W  = 9;                     // holds up to WNUM_STANDARD + 1
    localparam int ADDR_W = 32;                    // byte address into the GLB

    localparam int GLB_DEPTH = 256;                // words
    localparam int GLB_AW    = $clog2(GLB_DEPTH);  // word address width

    // which byte of the GLB word goes out on a read
    typedef enum logic [1:0] {
        LOAD_1BYTE = 2'd0,
        LOAD_2BYTE = 2'd1,
        LOAD_3BYTE = 2'd2,
        LOAD_4BYTE = 2'd3
    } byte_type_t;

    // host writes the whole word, the read side picks one byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;                    // bytes[0] is byte address 4n
    } glb_word_u;

    // descriptor register map
    localparam logic CFG_LAYER = 1'b0;
    localparam logic CFG_BASE  = 1'b1;

endpackage
